// ==== game_pkg.sv ====
`default_nettype none

package game_pkg;

    typedef logic [10:0] coord_t;

    typedef struct packed {
        coord_t top;
        coord_t left;
    } pos_t;

    typedef struct packed {
        logic   live;
        coord_t top;
        coord_t left;
    } shot_t;

    typedef logic [7:0] life_t;    // jet max of 25 fits as well
    typedef logic [3:0] hits_t;    // up to ten hits in one cycle

    // player jet
    localparam coord_t JET_HOME_TOP  = 11'd610;
    localparam coord_t JET_HOME_LEFT = 11'd448;
    localparam coord_t JET_TOP_MIN   = 11'd2;
    localparam coord_t JET_TOP_MAX   = 11'd633;
    localparam coord_t JET_LEFT_MAX  = 11'd896;
    localparam coord_t JET_W         = 11'd128;
    localparam coord_t JET_H         = 11'd105;

    // enemy
    localparam coord_t EN_HOME_TOP  = 11'd38;
    localparam coord_t EN_HOME_LEFT = 11'd340;
    localparam coord_t EN_TOP_MIN   = 11'd34;
    localparam coord_t EN_TOP_MAX   = 11'd200;
    localparam coord_t EN_LEFT_MIN  = 11'd5;
    localparam coord_t EN_LEFT_MAX  = 11'd768;
    localparam coord_t EN_W         = 11'd256;
    localparam coord_t EN_H         = 11'd201;

    // shots of both sides
    localparam int     SHOT_COUNT       = 10;
    localparam int     SHOT_PERIOD      = 1000;
    localparam int     SHOT_SPACING     = 100;
    localparam coord_t SHOT_DY          = 11'd23;
    localparam coord_t SHOT_DX          = 11'd61;
    localparam coord_t SHOT_W           = 11'd9;
    localparam coord_t SHOT_H           = 11'd24;
    localparam coord_t EN_SHOT_DY       = 11'd200;
    localparam coord_t EN_SHOT_DX       = 11'd116;
    localparam coord_t EN_SHOT_SIZE     = 11'd32;
    localparam coord_t EN_SHOT_FLOOR    = 11'd707;
    localparam coord_t EN_SHOT_LEFT_MIN = 11'd5;
    localparam coord_t EN_SHOT_LEFT_MAX = 11'd992;

    // barrage patterns and enemy wandering
    localparam int         STREAM_LEN   = 1500;
    localparam int         SPREAD_LEN   = 800;
    localparam int         SPREAD_FIRE  = 300;
    localparam int         BARRAGE_STEP = 2;
    localparam int         DIR_HOLD     = 500;
    localparam logic [7:0] LFSR_SEED    = 8'hff;
    localparam int         LFSR_HOLD    = 100;

    localparam life_t JET_LIFE_FULL = 8'd25;
    localparam life_t EN_LIFE_FULL  = 8'd200;

    // up, down, left, right
    localparam logic [3:0] BTN_UP    = 4'b1000;
    localparam logic [3:0] BTN_DOWN  = 4'b0100;
    localparam logic [3:0] BTN_LEFT  = 4'b0010;
    localparam logic [3:0] BTN_RIGHT = 4'b0001;

    // true when two boxes share at least one pixel
    function automatic logic boxes_overlap(input pos_t a, input coord_t a_h, input coord_t a_w,
                                           input pos_t b, input coord_t b_h, input coord_t b_w);
        logic [11:0] a_bot;
        logic [11:0] a_rgt;
        logic [11:0] b_bot;
        logic [11:0] b_rgt;
        a_bot = {1'b0, a.top} + {1'b0, a_h};    // one past the last row
        a_rgt = {1'b0, a.left} + {1'b0, a_w};
        b_bot = {1'b0, b.top} + {1'b0, b_h};
        b_rgt = {1'b0, b.left} + {1'b0, b_w};
        return ({1'b0, a.top} < b_bot) && ({1'b0, b.top} < a_bot) &&
               ({1'b0, a.left} < b_rgt) && ({1'b0, b.left} < a_rgt);
    endfunction

endpackage

`default_nettype wire

// ==== jet_motion.sv ====
`timescale 1ns/1ps
`default_nettype none

module jet_motion (
    input  wire             CLK_Scan,
    input  wire             rst_n,
    input  wire             start,
    input  wire [3:0]       btn,
    output game_pkg::pos_t  jet_pos
);
    import game_pkg::*;

    logic go_up;
    logic go_down;
    logic go_left;
    logic go_right;

    always_comb
    begin
        go_up    = 1'b0;
        go_down  = 1'b0;
        go_left  = 1'b0;
        go_right = 1'b0;
        case (btn)
            BTN_UP:    go_up    = 1'b1;
            BTN_DOWN:  go_down  = 1'b1;
            BTN_LEFT:  go_left  = 1'b1;
            BTN_RIGHT: go_right = 1'b1;
            BTN_UP | BTN_LEFT:
            begin
                go_up   = 1'b1;
                go_left = 1'b1;
            end
            BTN_UP | BTN_RIGHT:
            begin
                go_up    = 1'b1;
                go_right = 1'b1;
            end
            BTN_DOWN | BTN_LEFT:
            begin
                go_down = 1'b1;
                go_left = 1'b1;
            end
            BTN_DOWN | BTN_RIGHT:
            begin
                go_down  = 1'b1;
                go_right = 1'b1;
            end
            default: ;    // idle or conflicting buttons, jet holds
        endcase
    end

    always_ff @(posedge CLK_Scan)
    begin
        if (!rst_n || start)
        begin
            jet_pos.top  <= JET_HOME_TOP;
            jet_pos.left <= JET_HOME_LEFT;
        end
        else
        begin
            if (go_up && jet_pos.top > JET_TOP_MIN)
                jet_pos.top <= jet_pos.top - 11'd1;
            else if (go_down && jet_pos.top < JET_TOP_MAX)
                jet_pos.top <= jet_pos.top + 11'd1;

            if (go_left && jet_pos.left > 11'd0)
                jet_pos.left <= jet_pos.left - 11'd1;
            else if (go_right && jet_pos.left < JET_LEFT_MAX)
                jet_pos.left <= jet_pos.left + 11'd1;
        end
    end

endmodule

`default_nettype wire

// ==== enemy_motion.sv ====
`timescale 1ns/1ps
`default_nettype none

module enemy_motion (
    input  wire             CLK_Scan,
    input  wire             rst_n,
    input  wire             start,
    output game_pkg::pos_t  enemy_pos
);
    import game_pkg::*;

    localparam int LFSR_CNT_W = $clog2(LFSR_HOLD + 1);
    localparam int DIR_CNT_W  = $clog2(DIR_HOLD + 1);

    logic [7:0]            lfsr;
    logic [7:0]            lfsr_next;
    logic [LFSR_CNT_W-1:0] lfsr_cnt;
    logic [DIR_CNT_W-1:0]  dir_cnt;
    logic [2:0]            dir;
    logic                  can_down;
    logic                  can_up;
    logic                  can_left;
    logic                  can_right;

    // bit 7 feeds back into taps 1, 2, 4, 5 and wraps through bit 0
    assign lfsr_next = {lfsr[0] ^ lfsr[7], lfsr[7], lfsr[6] ^ lfsr[7], lfsr[5] ^ lfsr[7],
                        lfsr[4], lfsr[3] ^ lfsr[7], lfsr[2] ^ lfsr[7], lfsr[1]};

    assign can_down  = enemy_pos.top < EN_TOP_MAX;
    assign can_up    = enemy_pos.top > EN_TOP_MIN;
    assign can_left  = enemy_pos.left > EN_LEFT_MIN;
    assign can_right = enemy_pos.left < EN_LEFT_MAX;

    always_ff @(posedge CLK_Scan)
    begin
        if (!rst_n || start)
        begin
            lfsr     <= LFSR_SEED;
            lfsr_cnt <= '0;
        end
        else if (lfsr_cnt == LFSR_CNT_W'(LFSR_HOLD))
        begin
            lfsr_cnt <= '0;
            lfsr     <= lfsr_next;
        end
        else
            lfsr_cnt <= lfsr_cnt + 1'b1;
    end

    always_ff @(posedge CLK_Scan)
    begin
        if (!rst_n || start)
        begin
            enemy_pos.top  <= EN_HOME_TOP;
            enemy_pos.left <= EN_HOME_LEFT;
            dir_cnt        <= '0;
            dir            <= 3'd0;    // start drifting down
        end
        else
        begin
            if (dir_cnt == DIR_CNT_W'(DIR_HOLD))
            begin
                dir_cnt <= '0;
                dir     <= {lfsr[3], lfsr[6], lfsr[2]};
            end
            else
                dir_cnt <= dir_cnt + 1'b1;

            case (dir)
                3'd0: if (can_down) enemy_pos.top <= enemy_pos.top + 11'd1;
                3'd1: if (can_right) enemy_pos.left <= enemy_pos.left + 11'd1;
                3'd2: if (can_up) enemy_pos.top <= enemy_pos.top - 11'd1;
                3'd3: if (can_left) enemy_pos.left <= enemy_pos.left - 11'd1;
                3'd4: if (can_down && can_right)    // down right
                begin
                    enemy_pos.top  <= enemy_pos.top + 11'd1;
                    enemy_pos.left <= enemy_pos.left + 11'd1;
                end
                3'd5: if (can_down && can_left)
                begin
                    enemy_pos.top  <= enemy_pos.top + 11'd1;
                    enemy_pos.left <= enemy_pos.left - 11'd1;
                end
                3'd6: if (can_up && can_right)
                begin
                    enemy_pos.top  <= enemy_pos.top - 11'd1;
                    enemy_pos.left <= enemy_pos.left + 11'd1;
                end
                default: if (can_up && can_left)    // up left
                begin
                    enemy_pos.top  <= enemy_pos.top - 11'd1;
                    enemy_pos.left <= enemy_pos.left - 11'd1;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== shot_volley.sv ====
`timescale 1ns/1ps
`default_nettype none

module shot_volley (
    input  wire                  CLK_Scan,
    input  wire                  rst_n,
    input  wire                  start,
    input  wire game_pkg::pos_t  jet_pos,
    input  wire game_pkg::pos_t  enemy_pos,
    output game_pkg::hits_t      enemy_hits
);
    import game_pkg::*;

    localparam int CNT_W = $clog2(SHOT_PERIOD + 1);

    logic [CNT_W-1:0]      vol_cnt;
    shot_t                 shots [SHOT_COUNT];
    logic [SHOT_COUNT-1:0] hit;
    hits_t                 hit_sum;

    // hit test on the registered shots against the current enemy box
    always_comb
    begin
        hit_sum = '0;
        for (int n = 0; n < SHOT_COUNT; n++)
        begin
            hit[n] = shots[n].live &&
                     boxes_overlap(pos_t'({shots[n].top, shots[n].left}), SHOT_H, SHOT_W,
                                   enemy_pos, EN_H, EN_W);
            hit_sum = hit_sum + hits_t'(hit[n]);
        end
    end

    always_ff @(posedge CLK_Scan)
    begin
        if (!rst_n || start)
        begin
            vol_cnt    <= '0;
            enemy_hits <= '0;
            for (int n = 0; n < SHOT_COUNT; n++)
                shots[n].live <= 1'b0;
        end
        else
        begin
            vol_cnt    <= (vol_cnt == CNT_W'(SHOT_PERIOD)) ? '0 : vol_cnt + 1'b1;
            enemy_hits <= hit_sum;
            for (int n = 0; n < SHOT_COUNT; n++)
            begin
                if (vol_cnt == CNT_W'((n + 1) * SHOT_SPACING))
                begin
                    // leaves from the jet nose, spawn wins over flight
                    shots[n].live <= 1'b1;
                    shots[n].top  <= jet_pos.top - SHOT_DY;
                    shots[n].left <= jet_pos.left + SHOT_DX;
                end
                else if (shots[n].live)
                begin
                    if (shots[n].top == '0 || hit[n])
                        shots[n].live <= 1'b0;    // off screen or spent on the enemy
                    else
                        shots[n].top <= shots[n].top - 11'd1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== enemy_barrage.sv ====
`timescale 1ns/1ps
`default_nettype none

module enemy_barrage (
    input  wire                  CLK_Scan,
    input  wire                  rst_n,
    input  wire                  start,
    input  wire game_pkg::pos_t  enemy_pos,
    input  wire game_pkg::pos_t  jet_pos,
    output game_pkg::hits_t      jet_hits
);
    import game_pkg::*;

    localparam int CNT_W = $clog2(STREAM_LEN + BARRAGE_STEP + 1);

    logic [CNT_W-1:0]      bar_cnt;
    logic [2:0]            pat_idx;    // 0..1 stream, 2..5 spread
    logic                  stream;
    logic                  pat_end;
    shot_t                 shots [SHOT_COUNT];
    logic [SHOT_COUNT-1:0] spawn;
    logic [SHOT_COUNT-1:0] retire;
    logic [SHOT_COUNT-1:0] hit;
    hits_t                 hit_sum;

    assign stream  = pat_idx < 3'd2;
    assign pat_end = stream ? (bar_cnt >= CNT_W'(STREAM_LEN)) : (bar_cnt >= CNT_W'(SPREAD_LEN));

    always_comb
    begin
        hit_sum = '0;
        for (int n = 0; n < SHOT_COUNT; n++)
        begin
            // stream fires one by one, spread fires all at once
            spawn[n] = stream ? (bar_cnt == CNT_W'((n + 1) * SHOT_SPACING))
                              : (bar_cnt == CNT_W'(SPREAD_FIRE));
            retire[n] = shots[n].live &&
                        (shots[n].top >= EN_SHOT_FLOOR ||
                         (!stream && (shots[n].left <= EN_SHOT_LEFT_MIN ||
                                      shots[n].left >= EN_SHOT_LEFT_MAX)));
            hit[n] = shots[n].live && !retire[n] && !pat_end &&
                     boxes_overlap(pos_t'({shots[n].top, shots[n].left}),
                                   EN_SHOT_SIZE, EN_SHOT_SIZE, jet_pos, JET_H, JET_W);
            hit_sum = hit_sum + hits_t'(hit[n]);
        end
    end

    always_ff @(posedge CLK_Scan)
    begin
        if (!rst_n || start)
        begin
            bar_cnt  <= '0;
            pat_idx  <= 3'd0;
            jet_hits <= '0;
            for (int n = 0; n < SHOT_COUNT; n++)
                shots[n].live <= 1'b0;
        end
        else
        begin
            jet_hits <= hit_sum;
            if (pat_end)
            begin
                bar_cnt <= '0;
                pat_idx <= (pat_idx == 3'd5) ? 3'd0 : pat_idx + 3'd1;
            end
            else
                bar_cnt <= bar_cnt + CNT_W'(BARRAGE_STEP);

            for (int n = 0; n < SHOT_COUNT; n++)
            begin
                if (pat_end)
                    shots[n].live <= 1'b0;    // screen wiped between patterns
                else if (spawn[n])
                begin
                    shots[n].live <= 1'b1;
                    shots[n].top  <= enemy_pos.top + EN_SHOT_DY;
                    shots[n].left <= enemy_pos.left + EN_SHOT_DX;
                end
                else if (shots[n].live)
                begin
                    if (retire[n] || hit[n])
                        shots[n].live <= 1'b0;
                    else
                    begin
                        shots[n].top <= shots[n].top + 11'd2;    // falls two per cycle
                        // fan out, wider for higher shot numbers
                        if (!stream && n % 2 == 0)
                            shots[n].left <= shots[n].left + coord_t'(n / 2);
                        else if (!stream)
                            shots[n].left <= shots[n].left - coord_t'(n / 2);
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== life_tracker.sv ====
`timescale 1ns/1ps
`default_nettype none

module life_tracker (
    input  wire                   CLK_Scan,
    input  wire                   rst_n,
    input  wire                   start,
    input  wire game_pkg::hits_t  enemy_hits,
    input  wire game_pkg::hits_t  jet_hits,
    output game_pkg::life_t       jet_life,
    output game_pkg::life_t       enemy_life,
    output logic                  over,
    output logic                  result    // high on a win
);
    import game_pkg::*;

    // floor at zero
    function automatic life_t sat_sub(input life_t life, input hits_t hits);
        return (life > life_t'(hits)) ? life - life_t'(hits) : '0;
    endfunction

    always_ff @(posedge CLK_Scan)
    begin
        if (!rst_n || start)
        begin
            jet_life   <= JET_LIFE_FULL;
            enemy_life <= EN_LIFE_FULL;
            over       <= 1'b0;
            result     <= 1'b0;
        end
        else
        begin
            if (jet_life != '0 && enemy_life != '0)    // frozen once a side is down
            begin
                jet_life   <= sat_sub(jet_life, jet_hits);
                enemy_life <= sat_sub(enemy_life, enemy_hits);
            end
            if (jet_life == '0 || enemy_life == '0)
                over <= 1'b1;
            result <= (enemy_life == '0);
        end
    end

endmodule

`default_nettype wire

// ==== game_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module game_core (
    input  wire                   CLK_Scan,
    input  wire                   rst_n,
    input  wire                   start,
    input  wire [3:0]             btn,
    output wire game_pkg::pos_t   jet_pos,
    output wire game_pkg::pos_t   enemy_pos,
    output wire game_pkg::life_t  jet_life,
    output wire game_pkg::life_t  enemy_life,
    output wire                   over,
    output wire                   result
);
    import game_pkg::*;

    hits_t enemy_hits;    // player shots landing this cycle
    hits_t jet_hits;

    jet_motion u_jet (
        .CLK_Scan (CLK_Scan),
        .rst_n    (rst_n),
        .start    (start),
        .btn      (btn),
        .jet_pos  (jet_pos)
    );

    enemy_motion u_enemy (
        .CLK_Scan  (CLK_Scan),
        .rst_n     (rst_n),
        .start     (start),
        .enemy_pos (enemy_pos)
    );

    shot_volley u_volley (
        .CLK_Scan   (CLK_Scan),
        .rst_n      (rst_n),
        .start      (start),
        .jet_pos    (jet_pos),
        .enemy_pos  (enemy_pos),
        .enemy_hits (enemy_hits)
    );

    enemy_barrage u_barrage (
        .CLK_Scan  (CLK_Scan),
        .rst_n     (rst_n),
        .start     (start),
        .enemy_pos (enemy_pos),
        .jet_pos   (jet_pos),
        .jet_hits  (jet_hits)
    );

    life_tracker u_life (
        .CLK_Scan   (CLK_Scan),
        .rst_n      (rst_n),
        .start      (start),
        .enemy_hits (enemy_hits),
        .jet_hits   (jet_hits),
        .jet_life   (jet_life),
        .enemy_life (enemy_life),
        .over       (over),
        .result     (result)
    );

endmodule

`default_nettype wire

// ==== game_chk.sv ====
`timescale 1ns/1ps
`default_nettype none

module game_chk (
    input wire                  CLK_Scan,
    input wire                  rst_n,
    input wire                  start,
    input wire game_pkg::pos_t  enemy_pos,
    input wire game_pkg::life_t jet_life,
    input wire game_pkg::life_t enemy_life,
    input wire                  over
);
    import game_pkg::*;

    property enemy_in_bounds;
        @(posedge CLK_Scan) disable iff (!rst_n)
            enemy_pos.top >= EN_TOP_MIN && enemy_pos.top <= EN_TOP_MAX &&
            enemy_pos.left >= EN_LEFT_MIN && enemy_pos.left <= EN_LEFT_MAX;
    endproperty

    // over only clears through a restart
    property over_sticky;
        @(posedge CLK_Scan) disable iff (!rst_n)
            $past(over) && !over |-> $past(start) || !$past(rst_n);
    endproperty

    property lives_non_increasing;
        @(posedge CLK_Scan) disable iff (!rst_n)
            !over && $past(rst_n) && !$past(start) |->
                jet_life <= $past(jet_life) && enemy_life <= $past(enemy_life);
    endproperty

    assert property (enemy_in_bounds) else $error("enemy left its wandering bounds");
    assert property (over_sticky) else $error("over fell without reset or start");
    assert property (lives_non_increasing) else $error("a life increased during play");

endmodule

bind game_core game_chk u_chk (
    .CLK_Scan   (CLK_Scan),
    .rst_n      (rst_n),
    .start      (start),
    .enemy_pos  (enemy_pos),
    .jet_life   (jet_life),
    .enemy_life (enemy_life),
    .over       (over)
);

`default_nettype wire

// ==== tb_game.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_game;
    import game_pkg::*;

    localparam int ROWS        = 16;
    localparam int GAME_CYCLES = 30000;
    localparam int MID_CYCLES  = 1000;

    logic       CLK_Scan;
    logic       rst_n;
    logic       start;
    logic [3:0] btn;
    pos_t       jet_pos;
    pos_t       enemy_pos;
    life_t      jet_life;
    life_t      enemy_life;
    logic       over;
    logic       result;

    pos_t       exp_jet;    // reference jet position
    pos_t       prev_enemy;
    logic       enemy_armed  = 1'b0;
    int         enemy_errs   = 0;
    int         cycle_count  = 0;
    int         cycle_limit  = 1000000;
    int         tests_run    = 0;
    int         tests_failed = 0;
    int         total_errs   = 0;
    logic [3:0] row_btn [ROWS];
    int         row_hold [ROWS];

    game_core u_dut (
        .CLK_Scan   (CLK_Scan),
        .rst_n      (rst_n),
        .start      (start),
        .btn        (btn),
        .jet_pos    (jet_pos),
        .enemy_pos  (enemy_pos),
        .jet_life   (jet_life),
        .enemy_life (enemy_life),
        .over       (over),
        .result     (result)
    );

    initial CLK_Scan = 1'b0;
    always #50 CLK_Scan = ~CLK_Scan;

    function automatic int clamp(input int v, input int lo, input int hi);
        return (v < lo) ? lo : ((v > hi) ? hi : v);
    endfunction

    // one cycle of jet travel with each axis clamped on its own
    function automatic pos_t step_jet(input pos_t p, input logic [3:0] b);
        pos_t nxt;
        int   top;
        int   left;
        nxt = p;
        if ((b[3] && b[2]) || (b[1] && b[0]))
            return nxt;    // opposing buttons
        top  = int'(p.top) - int'(b[3]) + int'(b[2]);
        left = int'(p.left) - int'(b[1]) + int'(b[0]);
        nxt.top  = coord_t'(clamp(top, int'(JET_TOP_MIN), int'(JET_TOP_MAX)));
        nxt.left = coord_t'(clamp(left, 0, int'(JET_LEFT_MAX)));
        return nxt;
    endfunction

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp,
                         inout int errs);
        if (got !== exp)
        begin
            $display("ERROR %s: got 0x%h expected 0x%h at %0t", name, got, exp, $time);
            errs++;
        end
    endtask

    task automatic check_home(inout int errs);
        check("jet_pos.top", 32'(jet_pos.top), 32'(JET_HOME_TOP), errs);
        check("jet_pos.left", 32'(jet_pos.left), 32'(JET_HOME_LEFT), errs);
        check("enemy_pos.top", 32'(enemy_pos.top), 32'(EN_HOME_TOP), errs);
        check("enemy_pos.left", 32'(enemy_pos.left), 32'(EN_HOME_LEFT), errs);
        check("jet_life", 32'(jet_life), 32'(JET_LIFE_FULL), errs);
        check("enemy_life", 32'(enemy_life), 32'(EN_LIFE_FULL), errs);
        check("over", 32'(over), 32'd0, errs);
        check("result", 32'(result), 32'd0, errs);
    endtask

    task automatic pulse_start;
        @(posedge CLK_Scan);
        start <= 1'b1;
        @(posedge CLK_Scan);
        start <= 1'b0;
        @(negedge CLK_Scan);
    endtask

    task automatic report(input string name, input int errs);
        tests_run++;
        total_errs += errs;
        if (errs != 0)
        begin
            tests_failed++;
            $display("test %s: failed with %0d errors", name, errs);
        end
        else
            $display("test %s: ok", name);
    endtask

    // the DUT and this model both see btn as it was before the edge
    always @(posedge CLK_Scan)
    begin
        if (!rst_n || start)
        begin
            exp_jet.top  <= JET_HOME_TOP;
            exp_jet.left <= JET_HOME_LEFT;
        end
        else
            exp_jet <= step_jet(exp_jet, btn);
    end

    // enemy stays in its box and moves at most one unit per axis
    always @(negedge CLK_Scan)
    begin
        if (enemy_armed)
        begin
            check("enemy_pos.top", 32'(enemy_pos.top),
                  32'(clamp(int'(enemy_pos.top), int'(EN_TOP_MIN), int'(EN_TOP_MAX))),
                  enemy_errs);
            check("enemy_pos.left", 32'(enemy_pos.left),
                  32'(clamp(int'(enemy_pos.left), int'(EN_LEFT_MIN), int'(EN_LEFT_MAX))),
                  enemy_errs);
            check("enemy_pos.top step", 32'(enemy_pos.top),
                  32'(clamp(int'(enemy_pos.top), int'(prev_enemy.top) - 1,
                            int'(prev_enemy.top) + 1)), enemy_errs);
            check("enemy_pos.left step", 32'(enemy_pos.left),
                  32'(clamp(int'(enemy_pos.left), int'(prev_enemy.left) - 1,
                            int'(prev_enemy.left) + 1)), enemy_errs);
        end
        prev_enemy  = enemy_pos;
        enemy_armed = rst_n && !start;    // a restart jumps home
    end

    always @(posedge CLK_Scan)
    begin
        cycle_count++;
        if (cycle_count >= cycle_limit)
        begin
            $display("timeout: run did not finish within %0d cycles", cycle_limit);
            $display("TEST FAIL");
            $finish;
        end
    end

    initial
    begin
        int    hold_sum;
        int    errs;
        int    errs5;
        int    zero_at;
        logic  zero_seen;
        logic  en_hit_seen;
        life_t prev_jl;
        life_t prev_el;
        life_t frozen_jl;
        life_t frozen_el;

        rst_n = 1'b0;
        start = 1'b0;
        btn   = 4'b0000;
        void'($urandom(32'h54f1));

        // button code and hold cycles per row
        row_btn  = '{4'b0000, BTN_UP, BTN_DOWN, BTN_LEFT, BTN_RIGHT, BTN_UP | BTN_LEFT,
                     BTN_DOWN | BTN_RIGHT, 4'b1100, 4'b0011, 4'b1111, BTN_UP | BTN_RIGHT,
                     BTN_DOWN | BTN_LEFT, BTN_DOWN, 4'b0111, BTN_LEFT, 4'b0000};
        row_hold = '{5, 20, 60, 500, 950, 700, 100, 10, 10, 10, 0, 0, 0, 0, 0, 0};
        for (int r = 10; r < ROWS; r++)    // random holds from row 10 on
            row_hold[r] = 1 + int'($urandom % 40);
        hold_sum = 0;
        for (int r = 0; r < ROWS; r++)
            hold_sum += row_hold[r];
        cycle_limit = (hold_sum + GAME_CYCLES) * 11 / 10;

        repeat (16) @(posedge CLK_Scan);
        rst_n <= 1'b1;
        @(negedge CLK_Scan);
        errs = 0;
        check_home(errs);
        pulse_start;
        check_home(errs);
        report("1 reset and start", errs);

        errs = 0;
        for (int r = 0; r < ROWS; r++)
        begin
            repeat (row_hold[r])
            begin
                @(posedge CLK_Scan);
                btn <= row_btn[r];
                @(negedge CLK_Scan);
                check("jet_pos.top", 32'(jet_pos.top), 32'(exp_jet.top), errs);
                check("jet_pos.left", 32'(jet_pos.left), 32'(exp_jet.left), errs);
            end
        end
        @(posedge CLK_Scan);
        btn <= 4'b0000;
        @(negedge CLK_Scan);
        check("jet_pos.top", 32'(jet_pos.top), 32'(exp_jet.top), errs);
        check("jet_pos.left", 32'(jet_pos.left), 32'(exp_jet.left), errs);
        report("2 jet button table", errs);

        // jet parked at home while the game plays itself out
        errs        = 0;
        errs5       = 0;
        zero_seen   = 1'b0;
        en_hit_seen = 1'b0;
        zero_at     = 0;
        frozen_jl   = '0;
        frozen_el   = '0;
        pulse_start;
        prev_jl = jet_life;
        prev_el = enemy_life;
        for (int i = 0; i < GAME_CYCLES; i++)
        begin
            @(negedge CLK_Scan);
            // an underflow would wrap high and fail here
            check("jet_life", 32'(jet_life), 32'((jet_life > prev_jl) ? prev_jl : jet_life),
                  errs);
            check("enemy_life", 32'(enemy_life),
                  32'((enemy_life > prev_el) ? prev_el : enemy_life), errs);
            if (enemy_life < EN_LIFE_FULL)
                en_hit_seen = 1'b1;
            if (!zero_seen && (jet_life == 8'd0 || enemy_life == 8'd0))
            begin
                zero_seen = 1'b1;
                zero_at   = i;
                frozen_jl = jet_life;
                frozen_el = enemy_life;
            end
            if (!zero_seen)
                check("over", 32'(over), 32'd0, errs5);
            else if (i > zero_at)
            begin
                check("jet_life frozen", 32'(jet_life), 32'(frozen_jl), errs5);
                check("enemy_life frozen", 32'(enemy_life), 32'(frozen_el), errs5);
                if (i >= zero_at + 2)
                begin
                    check("over", 32'(over), 32'd1, errs5);
                    check("result", 32'(result), 32'(frozen_el == 8'd0), errs5);
                end
            end
            prev_jl = jet_life;
            prev_el = enemy_life;
        end
        if (!en_hit_seen)
        begin
            $display("enemy_life never dropped below full during the parked run");
            errs++;
        end
        report("4 lives while parked", errs);
        if (!zero_seen)
        begin
            $display("neither life reached zero during the parked run");
            errs5++;
        end
        report("5 game over", errs5);

        errs = 0;
        pulse_start;
        check_home(errs);
        @(posedge CLK_Scan);
        btn <= BTN_LEFT;    // jet leaves home before the restart
        repeat (MID_CYCLES) @(posedge CLK_Scan);
        btn <= 4'b0000;
        pulse_start;
        check_home(errs);
        report("6 restart mid-game", errs);

        report("3 enemy wandering", enemy_errs);

        $display("summary: %0d tests run, %0d failed, %0d errors", tests_run, tests_failed,
                 total_errs);
        if (tests_failed == 0)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim.f ====
game_pkg.sv
jet_motion.sv
enemy_motion.sv
shot_volley.sv
enemy_barrage.sv
life_tracker.sv
game_core.sv
game_chk.sv
tb_game.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := tb_game
FILELIST   := sim.f
BUILD_DIR  := obj_dir
LOG        := sim.log
LINT_FLAGS := --lint-only --timing --top-module $(TOP)
SIM_FLAGS  := --binary --timing --assert --top-module $(TOP) --Mdir $(BUILD_DIR) -o V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^TEST PASS$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
